/* logic/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    localparam int data_width = 32;                     // data, address and immediate width

    typedef enum logic [3:0] {
        op_nop,
        op_add,                                         // rd = rs + rt
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,                                         // signed compare, 1 or 0
        op_addi,                                        // rd = rs + imm
        op_lw,                                          // rd = mem[rs + imm]
        op_sw                                           // mem[rs + imm] = rt
    } op_t;

    function automatic logic op_writes_reg(input op_t op);
        return !(op == op_nop || op == op_sw);          // every op but nop and sw has an rd
    endfunction

    function automatic logic op_is_load(input op_t op);
        return op == op_lw;
    endfunction

    function automatic logic op_is_store(input op_t op);
        return op == op_sw;
    endfunction

    function automatic logic op_uses_imm(input op_t op);
        return op == op_addi || op == op_lw || op == op_sw;  // imm replaces operand b
    endfunction

endpackage

/* logic/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

    localparam int hazd_ctrl_width = 2;                 // width of a stage control vector
    localparam int hazd_hold_bit   = 0;                 // stage keeps its contents
    localparam int hazd_no_op_bit  = 1;                 // next stage gets a bubble

    // where an operand comes from
    typedef enum logic [1:0] {
        fwd_input,                                      // value read at issue
        fwd_alu_res,                                    // ex/mem alu result
        fwd_mem_res                                     // write-back data
    } fwd_sel_t;

endpackage

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file
    import cpu_isa_pkg::*;
#(
    parameter int reg_addr_width = 3
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [reg_addr_width-1:0] rs_idx,
    input  logic [reg_addr_width-1:0] rt_idx,
    output logic [data_width-1:0]     rs_data,
    output logic [data_width-1:0]     rt_data,
    input  logic                      we,               // from the write-back port
    input  logic [reg_addr_width-1:0] wr_idx,
    input  logic [data_width-1:0]     wr_data
);

    logic [data_width-1:0] regs [2**reg_addr_width];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_idx != '0) begin      // r0 stays zero
            regs[wr_idx] <= wr_data;
        end
    end

    // same-cycle write bypasses into the read ports
    assign rs_data = (rs_idx == '0) ? '0 : (we && wr_idx == rs_idx) ? wr_data : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 : (we && wr_idx == rt_idx) ? wr_data : regs[rt_idx];

endmodule

/* logic/forward_unit.sv */
`timescale 1ns/1ps

module forward_unit
    import pipe_ctrl_pkg::*;
#(
    parameter int reg_addr_width = 3
) (
    input  logic [reg_addr_width-1:0] ex_rs,            // sources of the op in ex
    input  logic [reg_addr_width-1:0] ex_rt,
    input  logic [reg_addr_width-1:0] mem_rd,           // destination held in ex/mem
    input  logic                      mem_writes_reg,
    input  logic                      mem_is_load,      // load data is not ready in ex/mem
    input  logic                      wb_valid,
    input  logic [reg_addr_width-1:0] wb_reg_idx,
    output fwd_sel_t                  fwd_a,
    output fwd_sel_t                  fwd_b,
    input  logic [reg_addr_width-1:0] mem_rt,           // rt of the store entering ex/mem
    output fwd_sel_t                  store_fwd
);

    // youngest producer wins, ex/mem before write-back
    function automatic fwd_sel_t pick(
        input logic [reg_addr_width-1:0] src,
        input logic [reg_addr_width-1:0] m_rd,
        input logic                      m_wr,
        input logic                      m_ld,
        input logic                      w_vld,
        input logic [reg_addr_width-1:0] w_idx
    );
        if (m_wr && !m_ld && m_rd != '0 && m_rd == src) begin
            return fwd_alu_res;
        end else if (w_vld && w_idx == src) begin   // wb_valid never carries r0
            return fwd_mem_res;
        end
        return fwd_input;
    endfunction

    always_comb begin
        fwd_a     = pick(ex_rs, mem_rd, mem_writes_reg, mem_is_load, wb_valid, wb_reg_idx);
        fwd_b     = pick(ex_rt, mem_rd, mem_writes_reg, mem_is_load, wb_valid, wb_reg_idx);
        store_fwd = pick(mem_rt, mem_rd, mem_writes_reg, mem_is_load, wb_valid, wb_reg_idx);
    end

endmodule

/* logic/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit
    import cpu_isa_pkg::*, pipe_ctrl_pkg::*;
#(
    parameter int reg_addr_width = 3
) (
    input  logic                       issue_valid,
    input  logic [reg_addr_width-1:0]  issue_rs,
    input  logic [reg_addr_width-1:0]  issue_rt,
    input  op_t                        ex_op,
    input  logic [reg_addr_width-1:0]  ex_rd,
    input  logic                       mem_busy,        // apb transfer still open
    output logic                       issue_ready,
    output logic [hazd_ctrl_width-1:0] ex_control,
    output logic [hazd_ctrl_width-1:0] mem_control
);

    logic load_use;

    // candidate needs a word the load in ex has not fetched yet
    assign load_use = issue_valid && op_is_load(ex_op) && ex_rd != '0
                      && (ex_rd == issue_rs || ex_rd == issue_rt);

    assign issue_ready = !load_use && !mem_busy;

    always_comb begin
        ex_control  = '0;
        mem_control = '0;
        if (mem_busy) begin
            ex_control[hazd_hold_bit]   = 1'b1;         // freeze ex, keeps a pending load too
            mem_control[hazd_hold_bit]  = 1'b1;         // ex/mem keeps the transfer
            mem_control[hazd_no_op_bit] = 1'b1;         // mem/wb gets bubbles
        end else if (load_use) begin
            ex_control[hazd_no_op_bit]  = 1'b1;         // one bubble behind the load
        end
    end

endmodule

/* logic/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage
    import cpu_isa_pkg::*, pipe_ctrl_pkg::*;
#(
    parameter int reg_addr_width = 3
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [hazd_ctrl_width-1:0] ex_control,      // hold / bubble from hazard_unit
    input  logic                       issue_fire,      // valid and ready this cycle
    input  op_t                        issue_op,
    input  logic [reg_addr_width-1:0]  issue_rd,
    input  logic [reg_addr_width-1:0]  issue_rs,
    input  logic [reg_addr_width-1:0]  issue_rt,
    input  logic [data_width-1:0]      issue_imm,
    input  logic [data_width-1:0]      rs_data,         // reg_file read at issue
    input  logic [data_width-1:0]      rt_data,
    input  fwd_sel_t                   fwd_a,
    input  fwd_sel_t                   fwd_b,
    input  logic [data_width-1:0]      mem_alu_result,  // ex/mem forwarding source
    input  logic [data_width-1:0]      wb_data,         // write-back forwarding source
    output op_t                        ex_op,
    output logic [reg_addr_width-1:0]  ex_rd,
    output logic [reg_addr_width-1:0]  ex_rs,
    output logic [reg_addr_width-1:0]  ex_rt,
    output logic [data_width-1:0]      ex_alu_result,
    output logic [data_width-1:0]      ex_store_data,   // raw rt, forwarded in ex_mem_reg
    output logic                       ex_no_op
);

    logic [data_width-1:0] rs_val;
    logic [data_width-1:0] rt_val;
    logic [data_width-1:0] imm;
    logic [data_width-1:0] op_a;
    logic [data_width-1:0] op_b_reg;                    // forwarded rt before the imm mux
    logic [data_width-1:0] op_b;

    function automatic logic [data_width-1:0] fwd_mux(
        input fwd_sel_t              sel,
        input logic [data_width-1:0] own,
        input logic [data_width-1:0] alu_res,
        input logic [data_width-1:0] mem_res
    );
        case (sel)
            fwd_alu_res: return alu_res;
            fwd_mem_res: return mem_res;
            default:     return own;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_op    <= op_nop;
            ex_rd    <= '0;
            ex_rs    <= '0;
            ex_rt    <= '0;
            ex_no_op <= 1'b1;
        end else if (!ex_control[hazd_hold_bit]) begin
            if (issue_fire && !ex_control[hazd_no_op_bit]) begin
                ex_op    <= issue_op;
                ex_rd    <= issue_rd;
                ex_rs    <= issue_rs;
                ex_rt    <= issue_rt;
                ex_no_op <= 1'b0;
            end else begin                              // bubble, or nothing issued
                ex_op    <= op_nop;
                ex_rd    <= '0;
                ex_rs    <= '0;
                ex_rt    <= '0;
                ex_no_op <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_control[hazd_hold_bit]) begin
            // wb bubbles during a stall, so keep what was forwarded
            rs_val <= op_a;
            rt_val <= op_b_reg;
        end else if (issue_fire) begin
            rs_val <= rs_data;
            rt_val <= rt_data;
            imm    <= issue_imm;
        end
    end

    always_comb begin
        op_a     = fwd_mux(fwd_a, rs_val, mem_alu_result, wb_data);
        op_b_reg = fwd_mux(fwd_b, rt_val, mem_alu_result, wb_data);
        op_b     = op_uses_imm(ex_op) ? imm : op_b_reg;
        case (ex_op)
            op_add, op_addi,
            op_lw, op_sw: ex_alu_result = op_a + op_b;  // sum is the address for memory ops
            op_sub:       ex_alu_result = op_a - op_b;
            op_and:       ex_alu_result = op_a & op_b;
            op_or:        ex_alu_result = op_a | op_b;
            op_xor:       ex_alu_result = op_a ^ op_b;
            op_slt:       ex_alu_result = {{(data_width-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default:      ex_alu_result = '0;
        endcase
    end

    assign ex_store_data = rt_val;

endmodule

/* logic/ex_mem_reg.sv */
`timescale 1ns/1ps

module ex_mem_reg
    import cpu_isa_pkg::*, pipe_ctrl_pkg::*;
#(
    parameter int reg_addr_width = 3
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [hazd_ctrl_width-1:0] hazard_control,  // hold keeps a pending transfer
    input  logic                       ex_no_op,
    input  op_t                        ex_op,
    input  logic [reg_addr_width-1:0]  ex_rd,
    input  logic [data_width-1:0]      ex_alu_result,
    input  logic [data_width-1:0]      ex_store_data,   // rt as read at issue
    input  fwd_sel_t                   store_data_select,
    input  logic [data_width-1:0]      mem_alu_result_prev,  // our own result, fed back
    input  logic [data_width-1:0]      wb_reg_write_data,
    output logic                       mem_no_op,
    output op_t                        mem_op,
    output logic [reg_addr_width-1:0]  mem_rd,
    output logic [data_width-1:0]      mem_alu_result,  // apb address, forwarding source
    output logic [data_width-1:0]      mem_store_data   // apb write data
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_no_op <= 1'b1;
            mem_op    <= op_nop;
            mem_rd    <= '0;
        end else if (!hazard_control[hazd_hold_bit]) begin
            mem_no_op <= hazard_control[hazd_no_op_bit] | ex_no_op;
            mem_op    <= ex_op;
            mem_rd    <= ex_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (!hazard_control[hazd_hold_bit]) begin
            mem_alu_result <= ex_alu_result;
            case (store_data_select)
                fwd_alu_res: mem_store_data <= mem_alu_result_prev;
                fwd_mem_res: mem_store_data <= wb_reg_write_data;
                default:     mem_store_data <= ex_store_data;
            endcase
        end
    end

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage
    import cpu_isa_pkg::*, pipe_ctrl_pkg::*;
#(
    parameter int reg_addr_width = 3,
    parameter int apb_addr_width = 12
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [hazd_ctrl_width-1:0] hazard_control,  // no-op puts a bubble into mem/wb
    input  logic                       mem_no_op,
    input  op_t                        mem_op,
    input  logic [reg_addr_width-1:0]  mem_rd,
    input  logic [data_width-1:0]      mem_alu_result,
    input  logic [data_width-1:0]      mem_store_data,
    output logic                       psel,
    output logic                       penable,
    output logic                       pwrite,
    output logic [apb_addr_width-1:0]  paddr,
    output logic [data_width-1:0]      pwdata,
    input  logic [data_width-1:0]      prdata,
    input  logic                       pready,
    output logic                       mem_busy,
    output logic                       wb_valid,
    output logic [reg_addr_width-1:0]  wb_reg_idx,
    output logic [data_width-1:0]      wb_data
);

    typedef enum logic [1:0] {
        idle,
        setup,
        access
    } apb_state_t;

    apb_state_t state_q;                                // holds only idle or access
    apb_state_t phase;                                  // apb phase of this cycle
    logic       mem_req;

    assign mem_req = !mem_no_op && (op_is_load(mem_op) || op_is_store(mem_op));

    // setup is the first cycle a memory op sits in ex/mem
    always_comb begin
        if (state_q == access) begin
            phase = access;
        end else if (mem_req) begin
            phase = setup;
        end else begin
            phase = idle;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= idle;
        end else if (phase == setup) begin
            state_q <= access;
        end else if (phase == access && pready) begin
            state_q <= idle;                            // ex/mem moves on this edge
        end
    end

    assign psel     = phase != idle;
    assign penable  = phase == access;
    assign pwrite   = psel && op_is_store(mem_op);
    assign paddr    = mem_alu_result[apb_addr_width-1:0];  // low address bits only
    assign pwdata   = mem_store_data;
    assign mem_busy = phase == setup || (phase == access && !pready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if (hazard_control[hazd_no_op_bit]) begin
            wb_valid <= 1'b0;
        end else if (!hazard_control[hazd_hold_bit]) begin
            wb_valid <= !mem_no_op && op_writes_reg(mem_op) && mem_rd != '0;  // r0 never shown
        end
    end

    always_ff @(posedge clk) begin
        if (!hazard_control[hazd_no_op_bit] && !hazard_control[hazd_hold_bit]) begin
            wb_reg_idx <= mem_rd;
            wb_data    <= op_is_load(mem_op) ? prdata : mem_alu_result;
        end
    end

endmodule

/* logic/exec_backend.sv */
`timescale 1ns/1ps

module exec_backend
    import cpu_isa_pkg::*, pipe_ctrl_pkg::*;
#(
    parameter int reg_addr_width = 3,                   // 8 registers
    parameter int apb_addr_width = 12
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      issue_valid,
    output logic                      issue_ready,
    input  op_t                       issue_op,
    input  logic [reg_addr_width-1:0] issue_rd,
    input  logic [reg_addr_width-1:0] issue_rs,
    input  logic [reg_addr_width-1:0] issue_rt,
    input  logic [data_width-1:0]     issue_imm,
    output logic                      psel,
    output logic                      penable,
    output logic                      pwrite,
    output logic [apb_addr_width-1:0] paddr,
    output logic [data_width-1:0]     pwdata,
    input  logic [data_width-1:0]     prdata,
    input  logic                      pready,
    output logic                      wb_valid,
    output logic [reg_addr_width-1:0] wb_reg_idx,
    output logic [data_width-1:0]     wb_data
);

    logic [hazd_ctrl_width-1:0] ex_control;
    logic [hazd_ctrl_width-1:0] mem_control;
    logic                       issue_fire;
    logic [data_width-1:0]      rs_data;
    logic [data_width-1:0]      rt_data;
    fwd_sel_t                   fwd_a;
    fwd_sel_t                   fwd_b;
    fwd_sel_t                   store_fwd;
    op_t                        ex_op;
    logic [reg_addr_width-1:0]  ex_rd;
    logic [reg_addr_width-1:0]  ex_rs;
    logic [reg_addr_width-1:0]  ex_rt;
    logic [data_width-1:0]      ex_alu_result;
    logic [data_width-1:0]      ex_store_data;
    logic                       ex_no_op;
    logic                       mem_no_op;
    op_t                        mem_op;
    logic [reg_addr_width-1:0]  mem_rd;
    logic [data_width-1:0]      mem_alu_result;
    logic [data_width-1:0]      mem_store_data;
    logic                       mem_busy;
    logic                       mem_writes_reg;
    logic                       mem_is_load;

    assign issue_fire     = issue_valid && issue_ready;
    assign mem_writes_reg = !mem_no_op && op_writes_reg(mem_op);
    assign mem_is_load    = op_is_load(mem_op);

    reg_file #(.reg_addr_width(reg_addr_width)) u_reg_file (
        .clk, .rst_n,
        .rs_idx(issue_rs), .rt_idx(issue_rt),
        .rs_data, .rt_data,
        .we(wb_valid), .wr_idx(wb_reg_idx), .wr_data(wb_data)  // write-back drives the write port
    );

    forward_unit #(.reg_addr_width(reg_addr_width)) u_forward_unit (
        .ex_rs, .ex_rt, .mem_rd, .mem_writes_reg, .mem_is_load,
        .wb_valid, .wb_reg_idx, .fwd_a, .fwd_b,
        .mem_rt(ex_rt),                                 // the store leaving ex
        .store_fwd
    );

    hazard_unit #(.reg_addr_width(reg_addr_width)) u_hazard_unit (
        .issue_valid, .issue_rs, .issue_rt, .ex_op, .ex_rd, .mem_busy,
        .issue_ready, .ex_control, .mem_control
    );

    ex_stage #(.reg_addr_width(reg_addr_width)) u_ex_stage (
        .clk, .rst_n, .ex_control, .issue_fire,
        .issue_op, .issue_rd, .issue_rs, .issue_rt, .issue_imm,
        .rs_data, .rt_data, .fwd_a, .fwd_b, .mem_alu_result, .wb_data,
        .ex_op, .ex_rd, .ex_rs, .ex_rt, .ex_alu_result, .ex_store_data, .ex_no_op
    );

    ex_mem_reg #(.reg_addr_width(reg_addr_width)) u_ex_mem_reg (
        .clk, .rst_n, .hazard_control(mem_control),
        .ex_no_op, .ex_op, .ex_rd, .ex_alu_result, .ex_store_data,
        .store_data_select(store_fwd),
        .mem_alu_result_prev(mem_alu_result),
        .wb_reg_write_data(wb_data),
        .mem_no_op, .mem_op, .mem_rd, .mem_alu_result, .mem_store_data
    );

    mem_stage #(
        .reg_addr_width(reg_addr_width),
        .apb_addr_width(apb_addr_width)
    ) u_mem_stage (
        .clk, .rst_n, .hazard_control(mem_control),
        .mem_no_op, .mem_op, .mem_rd, .mem_alu_result, .mem_store_data,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
        .mem_busy, .wb_valid, .wb_reg_idx, .wb_data
    );

endmodule

/* tb/exec_backend_sva.sv */
`timescale 1ns/1ps

module exec_backend_sva #(
    parameter int reg_addr_width = 3,
    parameter int apb_addr_width = 12
) (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      psel,
    input logic                      penable,
    input logic                      pwrite,
    input logic [apb_addr_width-1:0] paddr,
    input logic [31:0]               pwdata,
    input logic                      pready,
    input logic                      wb_valid,
    input logic [reg_addr_width-1:0] wb_reg_idx
);

    // access phase only right after a setup phase
    a_setup_first: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> $past(psel && !penable))
        else $error("penable without a setup cycle");

    a_setup_to_access: assert property (@(posedge clk) disable iff (!rst_n)
        psel && !penable |=> psel && penable)
        else $error("setup not followed by access");

    a_stable_wait: assert property (@(posedge clk) disable iff (!rst_n)
        psel && penable && !pready |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata))
        else $error("apb request changed during wait");

    a_no_r0_wb: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> wb_reg_idx != '0)
        else $error("write-back to r0");

endmodule

bind exec_backend exec_backend_sva #(
    .reg_addr_width(reg_addr_width),
    .apb_addr_width(apb_addr_width)
) u_sva (
    .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .pready(pready),
    .wb_valid(wb_valid), .wb_reg_idx(wb_reg_idx)
);

/* tb/exec_backend_tb.sv */
`timescale 1ns/1ps

module exec_backend_tb
    import cpu_isa_pkg::*;
;
    localparam int n_max = 32;

    logic clk = 1'b0;
    logic rst_n, issue_valid, issue_ready, psel, penable, pwrite, pready, wb_valid;
    op_t issue_op;
    logic [2:0] issue_rd, issue_rs, issue_rt, wb_reg_idx;
    logic [31:0] issue_imm, pwdata, prdata, wb_data;
    logic [11:0] paddr;

    op_t tbl_op [n_max];
    logic [2:0] tbl_rd [n_max], tbl_rs [n_max], tbl_rt [n_max];
    logic [31:0] tbl_imm [n_max];
    int tbl_grp [n_max];
    int n_tbl = 0;
    logic [31:0] ref_regs [8];
    logic [31:0] ref_mem [64];
    logic [31:0] slave_mem [64];
    logic [31:0] wb_exp_q [$];                          // {idx, data} kept in two queues
    logic [2:0] wb_idx_q [$];
    int wb_grp_q [$];
    logic [31:0] st_addr_q [$], st_data_q [$];
    int st_grp_q [$];
    int grp_left [5];
    int grp_err [5];
    string grp_name [5] = '{"alu ops", "forwarding", "stores", "load-use", "wait states"};
    logic [31:0] lfsr = 32'h3090;
    int errors = 0, checks = 0, cycles = 0, issued = 0, waits = 0;
    int limit;
    bit stall_seen = 0, in_setup, in_wait;

    exec_backend #(.reg_addr_width(3), .apb_addr_width(12)) dut0 (.*);

    always #5 clk = ~clk;

    function automatic bit lfsr_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);  // galois step
        return lfsr[0];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp,
                         input int grp);
        checks++;
        if (got !== exp) begin
            errors++;
            grp_err[grp]++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic add(input op_t op, input int rd, input int rs, input int rt,
                       input logic [31:0] imm, input int grp);
        tbl_op[n_tbl] = op;
        tbl_rd[n_tbl] = rd;
        tbl_rs[n_tbl] = rs;
        tbl_rt[n_tbl] = rt;
        tbl_imm[n_tbl] = imm;
        tbl_grp[n_tbl] = grp;
        n_tbl++;
    endtask

    // in-order model of the isa, predicts every write-back and store
    task automatic run_model();
        logic [31:0] a, b, r, ea;
        for (int i = 0; i < 64; i++) ref_mem[i] = 32'hc0de0000 | (i * 32'h00010111);
        slave_mem = ref_mem;
        foreach (ref_regs[i]) ref_regs[i] = '0;
        for (int i = 0; i < n_tbl; i++) begin
            a = ref_regs[tbl_rs[i]];
            b = ref_regs[tbl_rt[i]];
            ea = a + tbl_imm[i];
            case (tbl_op[i])
                op_add:  r = a + b;
                op_sub:  r = a - b;
                op_and:  r = a & b;
                op_or:   r = a | b;
                op_xor:  r = a ^ b;
                op_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                op_lw:   r = ref_mem[ea[7:2]];
                default: r = ea;                        // addi
            endcase
            if (tbl_op[i] == op_sw) begin
                ref_mem[ea[7:2]] = b;
                st_addr_q.push_back(ea & 32'hfff);
                st_data_q.push_back(b);
                st_grp_q.push_back(tbl_grp[i]);
                grp_left[tbl_grp[i]]++;
            end else if (tbl_rd[i] != 0) begin          // r0 writes stay invisible
                ref_regs[tbl_rd[i]] = r;
                wb_idx_q.push_back(tbl_rd[i]);
                wb_exp_q.push_back(r);
                wb_grp_q.push_back(tbl_grp[i]);
                grp_left[tbl_grp[i]]++;
            end
        end
    endtask

    task automatic note_done(input int g);
        grp_left[g]--;
        if (grp_left[g] == 0) begin
            if (g == 3) check("load-use stall", stall_seen, 1'b1, g);
            $display("test %0d %s: %0d errors", g, grp_name[g], grp_err[g]);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        issue_valid = 1'b0;
        issue_op = op_nop;
        issue_rd = '0;
        issue_rs = '0;
        issue_rt = '0;
        issue_imm = '0;
        pready = 1'b0;
        prdata = '0;
        add(op_addi, 1, 0, 0, 32'd5, 0);
        add(op_addi, 2, 0, 0, 32'hfffffffd, 0);
        add(op_add, 3, 1, 2, 0, 0);
        add(op_sub, 4, 1, 2, 0, 0);
        add(op_and, 5, 1, 2, 0, 0);
        add(op_or, 6, 1, 2, 0, 0);
        add(op_xor, 7, 1, 2, 0, 0);
        add(op_slt, 3, 2, 1, 0, 0);                     // -3 < 5 signed
        add(op_addi, 0, 1, 0, 32'd9, 0);
        add(op_addi, 1, 1, 0, 32'd1, 1);
        add(op_add, 2, 1, 1, 0, 1);
        add(op_sub, 3, 2, 1, 0, 1);
        add(op_addi, 4, 0, 0, 32'd16, 2);
        add(op_addi, 5, 0, 0, 32'h55, 2);
        add(op_sw, 0, 4, 5, 32'd0, 2);
        add(op_add, 6, 3, 2, 0, 2);
        add(op_sw, 0, 4, 6, 32'd4, 2);
        add(op_lw, 7, 4, 0, 32'd0, 3);
        add(op_add, 1, 7, 7, 0, 3);
        add(op_lw, 2, 4, 0, 32'd4, 4);
        add(op_sw, 0, 0, 1, 32'd8, 4);
        add(op_lw, 3, 0, 0, 32'd8, 4);
        add(op_add, 5, 3, 2, 0, 4);
        add(op_lw, 6, 0, 0, 32'd40, 4);                 // untouched word, fill pattern
        run_model();
        limit = n_tbl * 12 + 50;
        repeat (3) begin
            @(negedge clk);
            check("issue_ready", issue_ready, 1'b1, 0);
            check("psel", psel, 1'b0, 0);
            check("penable", penable, 1'b0, 0);
            check("wb_valid", wb_valid, 1'b0, 0);
        end
        @(posedge clk);
        #1 rst_n = 1'b1;
        $display("test reset state: %0d errors", errors);
        while ((issued < n_tbl || wb_exp_q.size() > 0 || st_addr_q.size() > 0)
               && cycles < limit) begin
            issue_valid = issued < n_tbl;
            if (issued < n_tbl) begin
                issue_op = tbl_op[issued];
                issue_rd = tbl_rd[issued];
                issue_rs = tbl_rs[issued];
                issue_rt = tbl_rt[issued];
                issue_imm = tbl_imm[issued];
            end
            @(negedge clk);
            cycles++;
            if (issue_valid && !issue_ready && issue_op == op_add && tbl_grp[issued] == 3
                && !(psel && !(penable && pready)))
                stall_seen = 1;                         // held by the load, apb not busy
            if (wb_valid) begin
                if (wb_exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected write-back to r%0d", wb_reg_idx);
                end else begin
                    check("wb_reg_idx", wb_reg_idx, wb_idx_q[0], wb_grp_q[0]);
                    check("wb_data", wb_data, wb_exp_q[0], wb_grp_q[0]);
                    void'(wb_idx_q.pop_front());
                    void'(wb_exp_q.pop_front());
                    note_done(wb_grp_q.pop_front());
                end
            end
            if (psel && penable && pready && pwrite) begin
                slave_mem[paddr[7:2]] = pwdata;
                if (st_addr_q.size() == 0) begin
                    errors++;
                    $display("unexpected store to address %h", paddr);
                end else begin
                    check("paddr", paddr, st_addr_q.pop_front(), st_grp_q[0]);
                    check("pwdata", pwdata, st_data_q.pop_front(), st_grp_q[0]);
                    note_done(st_grp_q.pop_front());
                end
            end
            in_setup = psel && !penable;
            in_wait = psel && penable && !pready;
            if (in_setup) waits = {lfsr_bit(), lfsr_bit()};  // 0 to 3 wait states
            if (issue_valid && issue_ready) issued++;
            @(posedge clk);
            #1;
            if (in_setup) begin
                pready = waits == 0;
            end else if (in_wait) begin
                waits--;
                pready = waits == 0;
            end else begin
                pready = 1'b0;
            end
            prdata = slave_mem[paddr[7:2]];
        end
        issue_valid = 1'b0;
        if (cycles >= limit) begin
            errors++;
            $display("timeout after %0d cycles, write-backs or stores still missing", cycles);
        end
        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* build.f */
logic/cpu_isa_pkg.sv
logic/pipe_ctrl_pkg.sv
logic/reg_file.sv
logic/forward_unit.sv
logic/hazard_unit.sv
logic/ex_stage.sv
logic/ex_mem_reg.sv
logic/mem_stage.sv
logic/exec_backend.sv
tb/exec_backend_sva.sv
tb/exec_backend_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= exec_backend_tb
FILELIST  ?= build.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); status=$$?; echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
